//--- logic/descriptor_queue.sv
/* Circular descriptor FIFO that drops its oldest entry on a push when full */

`timescale 1ns/1ns

module descriptor_queue
    import pf_train_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     push_i,
    input  pf_desc_t desc_i,
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output pf_desc_t desc_o
);

    pf_desc_t          mem_q [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QCNT_W-1:0] count_q;

    logic full;
    logic pop;
    logic drop;

    assign full        = (count_q == QCNT_W'(QUEUE_DEPTH));
    assign pop_valid_o = (count_q != '0);
    assign pop         = pop_valid_o && pop_ready_i;

    // Overwrite the oldest, unless a pop frees a slot this cycle
    assign drop = push_i && full && !pop;

    assign desc_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= desc_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop || drop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Push with pop, or push over a dropped entry, keeps the count
            if (push_i && !pop && !full) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= QCNT_W'(QUEUE_DEPTH))
        else $error("descriptor_queue: occupancy above depth");

endmodule : descriptor_queue

//--- logic/line_counter.sv
/* Counter of cache-line requests still to issue for the current descriptor */

`timescale 1ns/1ns

module line_counter
    import pf_train_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    load_i,
    input  pf_cfg_t count_i,
    input  logic    step_i,
    output logic    busy_o,
    output logic    last_o
);

    logic [NLINES_W-1:0] count_q;

    // A load wins over a step in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (load_i) begin
            count_q <= count_i.nlines;
        end else if (step_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign busy_o = (count_q != '0);
    assign last_o = (count_q == NLINES_W'(1));

    // Issuer only steps while it still owes requests
    a_step_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        step_i |-> busy_o)
        else $error("line_counter: step with no request pending");

endmodule : line_counter

//--- logic/pf_addr_pkg.sv
/* Address widths and address types: byte address, cache line, training region */

package pf_addr_pkg;

    // ********************
    // Widths
    // ********************

    // Byte address
    localparam int unsigned ADDR_W = 32;

    // 64-byte cache line
    localparam int unsigned LINE_OFFSET_W = 6;

    // 4 KiB training region
    localparam int unsigned REGION_OFFSET_W = 12;

    localparam int unsigned LINE_ADDR_W = ADDR_W - LINE_OFFSET_W;
    localparam int unsigned TAG_W = ADDR_W - REGION_OFFSET_W;

    // ********************
    // Types
    // ********************

    typedef logic [ADDR_W-1:0] addr_t;

    // Cache-line number, address without the line offset
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // Upper address bits, one tag per region
    typedef logic [TAG_W-1:0] region_tag_t;

    // Offset in the region, also a two's-complement stride
    typedef logic [REGION_OFFSET_W-1:0] region_off_t;

endpackage : pf_addr_pkg

//--- logic/pf_train_pkg.sv
/* Training table sizes, training states, table entry, prefetch descriptor,
   request and config types */

package pf_train_pkg;

    import pf_addr_pkg::*;

    // ********************
    // Sizes
    // ********************

    localparam int unsigned TABLE_ENTRIES = 4;
    localparam int unsigned TIDX_W = $clog2(TABLE_ENTRIES);
    localparam int unsigned LRU_W = 2;

    // Power of two, pointers wrap on their own
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QPTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned QCNT_W = $clog2(QUEUE_DEPTH + 1);

    // Lines per trigger
    localparam int unsigned NLINES_W = 4;
    localparam logic [NLINES_W-1:0] NLINES_RESET = 4'd4;

    // ********************
    // Types
    // ********************

    // Confirmation sequence, encodings in order
    typedef enum logic [2:0] {
        INITIAL     = 3'd0,
        STRIDE_DET  = 3'd1,
        HIT1        = 3'd2,
        HIT2        = 3'd3,
        HIT3        = 3'd4,
        PREFETCHING = 3'd5
    } train_state_e;

    typedef struct packed {
        logic         valid;
        region_tag_t  tag;
        train_state_e state;
        region_off_t  last_off;
        region_off_t  stride;
        logic [LRU_W-1:0] lru;    // 0 is most recent
    } table_entry_t;

    typedef struct packed {
        addr_t               trigger;
        region_off_t         stride;
        logic [NLINES_W-1:0] nlines;
    } pf_desc_t;

    typedef struct packed {
        line_addr_t line;
    } pf_req_t;

    typedef struct packed {
        logic [NLINES_W-1:0] nlines;
    } pf_cfg_t;

endpackage : pf_train_pkg

//--- logic/prefetch_issuer.sv
/* Descriptor issuer: pops descriptors and walks the stride, one line request
   per accepted valid/ready transfer */

`timescale 1ns/1ns

module prefetch_issuer
    import pf_addr_pkg::*;
    import pf_train_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     desc_valid_i,
    output logic     desc_ready_o,
    input  pf_desc_t desc_i,
    output logic     req_valid_o,
    input  logic     req_ready_i,
    output pf_req_t  req_o
);

    addr_t       addr_q;
    addr_t       base_sel;
    addr_t       next_addr;
    region_off_t stride_q;
    region_off_t stride_sel;
    pf_cfg_t     load_cnt;

    logic busy;
    logic last;
    logic step;
    logic pop;

    assign step = req_valid_o && req_ready_i;

    // Idle, or finishing with the last transfer this cycle
    assign desc_ready_o = !busy || (last && step);
    assign pop          = desc_valid_i && desc_ready_o;

    assign load_cnt.nlines = desc_i.nlines;

    // First line is trigger plus stride, then one stride per transfer
    assign stride_sel = pop ? desc_i.stride : stride_q;
    assign base_sel   = pop ? desc_i.trigger : addr_q;
    assign next_addr  = base_sel +
        {{(ADDR_W - REGION_OFFSET_W){stride_sel[REGION_OFFSET_W-1]}}, stride_sel};

    always_ff @(posedge clk_i) begin
        if (pop) begin
            stride_q <= desc_i.stride;
        end
        if (pop || step) begin
            addr_q <= next_addr;
        end
    end

    line_counter i_line_counter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .load_i  (pop),
        .count_i (load_cnt),
        .step_i  (step),
        .busy_o  (busy),
        .last_o  (last)
    );

    assign req_valid_o = busy;
    assign req_o.line  = addr_q[ADDR_W-1:LINE_OFFSET_W];

    // A stalled request stays up and unchanged
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o))
        else $error("prefetch_issuer: request dropped or changed under back-pressure");

endmodule : prefetch_issuer

//--- logic/stride_prefetcher.sv
/* Stride prefetcher top: training table, descriptor queue and issuer */

`timescale 1ns/1ns

module stride_prefetcher
    import pf_addr_pkg::*;
    import pf_train_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    snoop_valid_i,
    input  addr_t   snoop_addr_i,
    input  logic    cfg_valid_i,
    input  pf_cfg_t cfg_i,
    output logic    req_valid_o,
    input  logic    req_ready_i,
    output pf_req_t req_o
);

    // Table to queue
    logic     push;
    pf_desc_t push_desc;

    // Queue to issuer
    logic     q_valid;
    logic     q_ready;
    pf_desc_t q_desc;

    stride_table i_stride_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .snoop_valid_i (snoop_valid_i),
        .snoop_addr_i  (snoop_addr_i),
        .cfg_valid_i   (cfg_valid_i),
        .cfg_i         (cfg_i),
        .push_o        (push),
        .desc_o        (push_desc)
    );

    descriptor_queue i_descriptor_queue (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .desc_i      (push_desc),
        .pop_valid_o (q_valid),
        .pop_ready_i (q_ready),
        .desc_o      (q_desc)
    );

    prefetch_issuer i_prefetch_issuer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .desc_valid_i (q_valid),
        .desc_ready_o (q_ready),
        .desc_i       (q_desc),
        .req_valid_o  (req_valid_o),
        .req_ready_i  (req_ready_i),
        .req_o        (req_o)
    );

endmodule : stride_prefetcher

//--- logic/stride_table.sv
/* Fully associative stride training table with per-entry confirmation FSM,
   LRU replacement and the lines-per-trigger register */

`timescale 1ns/1ns

module stride_table
    import pf_addr_pkg::*;
    import pf_train_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     snoop_valid_i,
    input  addr_t    snoop_addr_i,
    input  logic     cfg_valid_i,
    input  pf_cfg_t  cfg_i,
    output logic     push_o,
    output pf_desc_t desc_o
);

    table_entry_t table_q [TABLE_ENTRIES];
    table_entry_t table_d [TABLE_ENTRIES];
    table_entry_t cur;
    pf_cfg_t      cfg_q;

    region_tag_t  snoop_tag;
    region_off_t  snoop_off;
    region_off_t  new_stride;
    region_off_t  expected_off;

    logic              hit;
    logic              has_free;
    logic [TIDX_W-1:0] hit_idx;
    logic [TIDX_W-1:0] fill_idx;
    logic [TIDX_W-1:0] sel_idx;
    logic              dup_tag;

    assign snoop_tag = snoop_addr_i[ADDR_W-1:REGION_OFFSET_W];
    assign snoop_off = snoop_addr_i[REGION_OFFSET_W-1:0];

    // ********************
    // Lookup and victim
    // ********************

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            if (!hit && table_q[i].valid && table_q[i].tag == snoop_tag) begin
                hit     = 1'b1;
                hit_idx = TIDX_W'(i);
            end
        end
    end

    // First invalid entry, else the least recently used one
    always_comb begin
        has_free = 1'b0;
        fill_idx = '0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            if (!has_free && !table_q[i].valid) begin
                has_free = 1'b1;
                fill_idx = TIDX_W'(i);
            end
        end
        if (!has_free) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                if (table_q[i].lru == LRU_W'(TABLE_ENTRIES - 1)) begin
                    fill_idx = TIDX_W'(i);
                end
            end
        end
    end

    assign sel_idx      = hit ? hit_idx : fill_idx;
    assign cur          = table_q[sel_idx];
    assign new_stride   = snoop_off - cur.last_off;
    assign expected_off = cur.last_off + cur.stride;

    // ********************
    // Entry update
    // ********************

    always_comb begin
        table_d = table_q;
        push_o  = 1'b0;
        if (snoop_valid_i) begin
            // Age everything more recent than the touched entry
            for (int k = 0; k < TABLE_ENTRIES; k++) begin
                if (table_q[k].lru < cur.lru) begin
                    table_d[k].lru = table_q[k].lru + 1'b1;
                end
            end
            table_d[sel_idx].lru      = '0;
            table_d[sel_idx].last_off = snoop_off;

            if (!hit) begin
                table_d[sel_idx].valid  = 1'b1;
                table_d[sel_idx].tag    = snoop_tag;
                table_d[sel_idx].state  = INITIAL;
                table_d[sel_idx].stride = '0;
            end else begin
                case (cur.state)
                    INITIAL: begin
                        table_d[sel_idx].stride = new_stride;
                        table_d[sel_idx].state  = STRIDE_DET;
                    end
                    STRIDE_DET, HIT1, HIT2, HIT3: begin
                        if (snoop_off == expected_off) begin
                            table_d[sel_idx].state = train_state_e'(cur.state + 3'd1);
                        end else begin
                            // Broken stream, retrain from the new difference
                            table_d[sel_idx].state  = INITIAL;
                            table_d[sel_idx].stride = new_stride;
                        end
                    end
                    PREFETCHING: begin
                        push_o                  = 1'b1;
                        table_d[sel_idx].state  = INITIAL;
                        table_d[sel_idx].stride = '0;
                    end
                    default: begin
                        table_d[sel_idx].state = INITIAL;
                    end
                endcase
            end
        end
    end

    // Descriptor is only meaningful together with push_o
    always_comb begin
        desc_o.trigger = snoop_addr_i;
        desc_o.stride  = cur.stride;
        desc_o.nlines  = cfg_q.nlines;
    end

    // Ranks start as a permutation so replacement always finds a victim
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                table_q[i].valid    <= 1'b0;
                table_q[i].tag      <= '0;
                table_q[i].state    <= INITIAL;
                table_q[i].last_off <= '0;
                table_q[i].stride   <= '0;
                table_q[i].lru      <= LRU_W'(i);
            end
        end else begin
            table_q <= table_d;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q.nlines <= NLINES_RESET;
        end else if (cfg_valid_i) begin
            cfg_q <= cfg_i;
        end
    end

    // ********************
    // Assertions
    // ********************

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            for (int j = i + 1; j < TABLE_ENTRIES; j++) begin
                if (table_q[i].valid && table_q[j].valid &&
                    table_q[i].tag == table_q[j].tag) begin
                    dup_tag = 1'b1;
                end
            end
        end
    end

    // A region is tracked by one entry at most
    a_unique_tags: assert property (@(posedge clk_i) disable iff (!rst_ni) !dup_tag)
        else $error("stride_table: two valid entries hold the same tag");

endmodule : stride_table

//--- run_sim.sh
#!/bin/sh
# Build the stride prefetcher testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f stride_prefetcher.f \
    --top-module tb_stride_prefetcher \
    -o sim_stride_prefetcher
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_stride_prefetcher 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Verification passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- stride_prefetcher.f
+incdir+tb
logic/pf_addr_pkg.sv
logic/pf_train_pkg.sv
logic/line_counter.sv
logic/descriptor_queue.sv
logic/stride_table.sv
logic/prefetch_issuer.sv
logic/stride_prefetcher.sv
tb/tb_stride_prefetcher.sv

//--- tb/tb_tasks.svh
/* Testbench helpers: value check, bounded waits, snoop and config drivers,
   reference line rule and request stream check */

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ********************
// Checks and waits
// ********************

task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
        $display("error: time %0t, signal %s, got 0x%0h, expected 0x%0h",
                 $time, name, got, exp);
        $display("Verification failed");
        $fatal(1);
    end
endtask

// Poll on the falling edge so monitor pushes have settled
task automatic wait_requests(int count, int limit);
    int cycles;
    cycles = 0;
    while (got_q.size() < count) begin
        if (cycles >= limit) begin
            $display("timeout: only %0d of %0d prefetch requests arrived within %0d cycles",
                     got_q.size(), count, limit);
            $display("Verification failed");
            $fatal(1);
        end else begin
            @(negedge clk_i);
            cycles++;
        end
    end
endtask

// Window in which no further request may show up
task automatic expect_quiet(int cycles, int count);
    repeat (cycles) @(negedge clk_i);
    check_value("prefetch request count", 32'(got_q.size()), 32'(count));
endtask

// ********************
// Stimulus
// ********************

task automatic snoop(addr_t addr);
    @(posedge clk_i);
    snoop_valid_i <= 1'b1;
    snoop_addr_i  <= addr;
    @(posedge clk_i);
    snoop_valid_i <= 1'b0;
endtask

task automatic set_lines(int count);
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_i.nlines <= NLINES_W'(count);
    @(posedge clk_i);
    cfg_valid_i <= 1'b0;
    nlines_cur = count;
endtask

// Accesses base + k*stride for k from first_k to last_k
task automatic train_stream(addr_t base, region_off_t stride, int first_k, int last_k);
    for (int k = first_k; k <= last_k; k++) begin
        snoop(base + sext_stride(stride) * addr_t'(k));
    end
endtask

// ********************
// Reference rule
// ********************

function automatic addr_t sext_stride(region_off_t stride);
    return {{(ADDR_W - REGION_OFFSET_W){stride[REGION_OFFSET_W-1]}}, stride};
endfunction

// Line k of a trigger with k counting from 1
function automatic line_addr_t expected_line(addr_t trig, region_off_t stride, int k);
    addr_t byte_addr;
    byte_addr = trig + sext_stride(stride) * addr_t'(k);
    return byte_addr[ADDR_W-1:LINE_OFFSET_W];
endfunction

task automatic check_stream(addr_t trig, region_off_t stride, int count, int first);
    for (int k = 1; k <= count; k++) begin
        check_value("req_o.line", 32'(got_q[first + k - 1]),
                    32'(expected_line(trig, stride, k)));
    end
endtask

`endif

//--- tb/tb_stride_prefetcher.sv
/* Stride prefetcher testbench: clock, reset, DUT, ready driver, request
   monitor and directed tests */

`timescale 1ns/1ns

module tb_stride_prefetcher
    import pf_addr_pkg::*;
    import pf_train_pkg::*;
();

    logic    clk_i = 1'b0;
    logic    rst_ni;
    logic    snoop_valid_i;
    addr_t   snoop_addr_i;
    logic    cfg_valid_i;
    pf_cfg_t cfg_i;
    logic    req_valid_o;
    logic    req_ready_i;
    pf_req_t req_o;

    line_addr_t got_q[$];
    int         nlines_cur;
    logic       ready_random;
    logic       ready_low;

    `include "tb_tasks.svh"

    always #20 clk_i = ~clk_i;

    stride_prefetcher i_dut (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .snoop_valid_i (snoop_valid_i),
        .snoop_addr_i  (snoop_addr_i),
        .cfg_valid_i   (cfg_valid_i),
        .cfg_i         (cfg_i),
        .req_valid_o   (req_valid_o),
        .req_ready_i   (req_ready_i),
        .req_o         (req_o)
    );

    // Ready pattern for the request port
    always @(posedge clk_i) begin
        if (ready_random) begin
            req_ready_i <= 1'($urandom);
        end else begin
            req_ready_i <= !ready_low;
        end
    end

    // Accepted requests, in order
    always @(posedge clk_i) begin
        if (rst_ni && req_valid_o && req_ready_i) begin
            got_q.push_back(req_o.line);
        end
    end

    // ********************
    // Tests
    // ********************

    task automatic test_positive_stride();
        addr_t base;
        addr_t trig;
        got_q.delete();
        base = 32'h1000_1080;
        train_stream(base, 12'h040, 0, 6);
        trig = base + sext_stride(12'h040) * 6;
        wait_requests(nlines_cur, 100);
        expect_quiet(20, nlines_cur);
        check_stream(trig, 12'h040, nlines_cur, 0);
    endtask

    task automatic test_negative_stride();
        addr_t base;
        addr_t trig;
        got_q.delete();
        set_lines(7);
        base = 32'h2000_2F00;
        train_stream(base, 12'hFC0, 0, 6);
        trig = base + sext_stride(12'hFC0) * 6;
        wait_requests(7, 100);
        expect_quiet(20, 7);
        check_stream(trig, 12'hFC0, 7, 0);
    endtask

    task automatic test_training_break();
        addr_t base;
        addr_t restart;
        got_q.delete();
        base = 32'h3000_3100;
        train_stream(base, 12'h040, 0, 3);
        // Off by 0x10 from the stream
        restart = base + sext_stride(12'h040) * 4 + 32'h10;
        snoop(restart);
        train_stream(restart, 12'h040, 1, 2);
        // An unbroken stream fires on this seventh access
        expect_quiet(8, 0);
        train_stream(restart, 12'h040, 3, 6);
        wait_requests(nlines_cur, 100);
        expect_quiet(20, nlines_cur);
        check_stream(restart + sext_stride(12'h040) * 6, 12'h040, nlines_cur, 0);
    endtask

    task automatic test_lru_eviction();
        addr_t       base;
        logic [31:0] rnd;
        got_q.delete();
        base = 32'h4000_4040;
        train_stream(base, 12'h080, 0, 2);
        rnd = $urandom;
        for (int i = 1; i <= 4; i++) begin
            snoop({4'hB, 16'(rnd[15:0] + 16'(i)), 12'h100});
        end
        // Evicted entry starts over from INITIAL at k = 3
        train_stream(base, 12'h080, 3, 8);
        expect_quiet(8, 0);
        train_stream(base, 12'h080, 9, 9);
        wait_requests(nlines_cur, 100);
        expect_quiet(20, nlines_cur);
        check_stream(base + sext_stride(12'h080) * 9, 12'h080, nlines_cur, 0);
    endtask

    task automatic test_backpressure();
        addr_t       base;
        addr_t       trig_list[6];
        region_off_t stride_list[6];
        logic [31:0] rnd;
        int          slot;

        // Random ready, single trigger
        got_q.delete();
        rnd = $urandom;
        base = {4'hD, rnd[15:0], 2'b00, rnd[19:16], 6'h00};
        @(negedge clk_i);
        ready_random = 1'b1;
        train_stream(base, 12'h040, 0, 6);
        wait_requests(nlines_cur, 400);
        @(negedge clk_i);
        ready_random = 1'b0;
        expect_quiet(20, nlines_cur);
        check_stream(base + sext_stride(12'h040) * 6, 12'h040, nlines_cur, 0);

        // Ready held low through six triggers
        got_q.delete();
        @(negedge clk_i);
        ready_low = 1'b1;
        rnd = $urandom;
        for (int i = 0; i < 6; i++) begin
            base = {4'hC, 16'(rnd[15:0] + 16'(i)), 12'h100};
            stride_list[i] = 12'(64 * (i + 1));
            train_stream(base, stride_list[i], 0, 6);
            trig_list[i] = base + sext_stride(stride_list[i]) * 6;
        end
        // First line of the first trigger waits at the port
        @(negedge clk_i);
        check_value("req_valid_o", 32'(req_valid_o), 32'd1);
        check_value("req_o.line", 32'(req_o.line),
                    32'(expected_line(trig_list[0], stride_list[0], 1)));
        ready_low = 1'b0;
        wait_requests(5 * nlines_cur, 400);
        expect_quiet(20, 5 * nlines_cur);
        // Second trigger was the oldest queued one when the sixth arrived
        slot = 0;
        for (int i = 0; i < 6; i++) begin
            if (i != 1) begin
                check_stream(trig_list[i], stride_list[i], nlines_cur, slot * nlines_cur);
                slot++;
            end
        end
    endtask

    // ********************
    // Sequence
    // ********************

    initial begin
        void'($urandom(92));
        rst_ni        <= 1'b0;
        snoop_valid_i <= 1'b0;
        snoop_addr_i  <= '0;
        cfg_valid_i   <= 1'b0;
        cfg_i         <= '0;
        req_ready_i   <= 1'b0;
        ready_random  = 1'b0;
        ready_low     = 1'b0;
        nlines_cur    = int'(NLINES_RESET);
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);

        test_positive_stride();
        test_negative_stride();
        test_training_break();
        test_lru_eviction();
        test_backpressure();

        $display("Verification passed");
        $finish;
    end

endmodule : tb_stride_prefetcher
